/* src/spi_link_pkg.sv */
// ============================================================
// SPI link framing
// ============================================================
package spi_link_pkg;

  // endpoint address field width
  localparam int ADDR_BITS = 4;

  // payload field width
  localparam int DATA_BITS = 16;

  // one frame on the wire, address on top
  localparam int FRAME_BITS = ADDR_BITS + DATA_BITS;

  // payload word
  typedef logic [DATA_BITS-1:0] data_t;

  // address in [19:16], data in [15:0]
  typedef logic [FRAME_BITS-1:0] frame_t;

endpackage

/* src/endpoint_pkg.sv */
// ============================================================
// endpoint address map and endpoint constants
// ============================================================
package endpoint_pkg;

  // mapped endpoints, anything else is answered with the error reply
  typedef enum logic [spi_link_pkg::ADDR_BITS-1:0] {
    EP_BIN      = 4'd4,
    EP_CUT_BIN  = 4'd6,
    EP_CUT_MAG  = 4'd7,
    EP_LOOPBACK = 4'd9
  } ep_addr_e;

  // magnitudes per classifier block
  localparam int N_BINS = 8;
  localparam int BIN_BITS = $clog2(N_BINS);

  typedef logic [BIN_BITS-1:0] bin_idx_t;

  // cutoff registers out of reset
  localparam bin_idx_t CUT_BIN_RESET = '0;
  localparam spi_link_pkg::data_t CUT_MAG_RESET = 16'h7FFF;

  // reply to an unmapped address
  localparam logic [spi_link_pkg::ADDR_BITS-1:0] BAD_ADDR_REPLY = 4'hF;
  localparam spi_link_pkg::data_t BAD_DATA_REPLY = 16'hDEAD;

  // set in the classifier reply on the last sample of a block
  localparam int BLOCK_DONE_BIT = 8;

endpackage

/* src/spi_minion.sv */
`timescale 1ns/1ps

module spi_minion (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 cs_n_i,
  input  logic                 sclk_i,
  input  logic                 mosi_i,
  input  spi_link_pkg::frame_t tx_frame_i,
  output logic                 miso_o,
  output logic                 rx_stb_o,
  output spi_link_pkg::frame_t rx_frame_o
);
  import spi_link_pkg::*;

  // counts to FRAME_BITS + 1 so an overlong frame is seen as bad
  localparam int CNT_BITS = $clog2(FRAME_BITS + 2);

  typedef enum logic {
    ST_IDLE,
    ST_SHIFT
  } state_e;

  state_e              state_q;
  logic [1:0]          cs_sync_q;
  logic [1:0]          sclk_sync_q;
  logic [1:0]          mosi_sync_q;
  logic                sclk_prev_q;
  logic                sclk_rise;
  logic                sclk_fall;
  logic [CNT_BITS-1:0] bit_cnt_q;
  frame_t              rx_shift_q;
  frame_t              tx_shift_q;

  // ============================================================
  // synchronizers and sclk edge detect
  // ============================================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cs_sync_q   <= 2'b11;
      sclk_sync_q <= 2'b00;
      sclk_prev_q <= 1'b0;
    end else begin
      cs_sync_q   <= {cs_sync_q[0], cs_n_i};
      sclk_sync_q <= {sclk_sync_q[0], sclk_i};
      sclk_prev_q <= sclk_sync_q[1];
    end
  end

  // same depth as sclk so the sample lines up with the rising edge
  always_ff @(posedge clk_i) begin
    mosi_sync_q <= {mosi_sync_q[0], mosi_i};
  end

  assign sclk_rise = sclk_sync_q[1] & ~sclk_prev_q;
  assign sclk_fall = ~sclk_sync_q[1] & sclk_prev_q;

  // ============================================================
  // frame FSM
  // ============================================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      bit_cnt_q <= '0;
      rx_stb_o  <= 1'b0;
    end else begin
      rx_stb_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (!cs_sync_q[1]) begin
            state_q   <= ST_SHIFT;
            bit_cnt_q <= '0;
          end
        end
        ST_SHIFT: begin
          if (cs_sync_q[1]) begin
            state_q <= ST_IDLE;
            // only a full frame goes to the router
            rx_stb_o <= (bit_cnt_q == CNT_BITS'(FRAME_BITS));
          end else if (sclk_rise && (bit_cnt_q <= CNT_BITS'(FRAME_BITS))) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // shift registers, MSB first both ways
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE) begin
      tx_shift_q <= tx_frame_i;
    end else begin
      if (sclk_rise) begin
        rx_shift_q <= {rx_shift_q[FRAME_BITS-2:0], mosi_sync_q[1]};
      end
      if (sclk_fall) begin
        tx_shift_q <= {tx_shift_q[FRAME_BITS-2:0], 1'b0};
      end
      if (cs_sync_q[1]) begin
        rx_frame_o <= rx_shift_q;
      end
    end
  end

  // bit 19 is on the line as soon as cs falls
  assign miso_o = (state_q == ST_IDLE) ? tx_frame_i[FRAME_BITS-1] : tx_shift_q[FRAME_BITS-1];

endmodule

/* src/frame_router.sv */
`timescale 1ns/1ps

module frame_router (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   rx_stb_i,
  input  spi_link_pkg::frame_t   rx_frame_i,
  output spi_link_pkg::data_t    payload_o,
  output logic                   cfg_stb_o,
  output logic                   cfg_sel_mag_o,
  output logic                   bin_stb_o,
  output logic                   loop_stb_o,
  output logic                   bad_stb_o,
  output endpoint_pkg::ep_addr_e bad_addr_o
);
  import spi_link_pkg::*;
  import endpoint_pkg::*;

  ep_addr_e rx_addr;

  // unmapped codes pass through the cast unchanged
  assign rx_addr = ep_addr_e'(rx_frame_i[FRAME_BITS-1 -: ADDR_BITS]);

  // one strobe per received frame
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_stb_o  <= 1'b0;
      bin_stb_o  <= 1'b0;
      loop_stb_o <= 1'b0;
      bad_stb_o  <= 1'b0;
    end else begin
      cfg_stb_o  <= rx_stb_i && (rx_addr inside {EP_CUT_BIN, EP_CUT_MAG});
      bin_stb_o  <= rx_stb_i && (rx_addr == EP_BIN);
      loop_stb_o <= rx_stb_i && (rx_addr == EP_LOOPBACK);
      bad_stb_o  <= rx_stb_i && !(rx_addr inside {EP_BIN, EP_CUT_BIN, EP_CUT_MAG, EP_LOOPBACK});
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_stb_i) begin
      payload_o     <= rx_frame_i[DATA_BITS-1:0];
      cfg_sel_mag_o <= (rx_addr == EP_CUT_MAG);
      bad_addr_o    <= rx_addr;
    end
  end

endmodule

/* src/config_bank.sv */
`timescale 1ns/1ps

module config_bank (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cfg_stb_i,
  input  logic                   cfg_sel_mag_i,
  input  spi_link_pkg::data_t    payload_i,
  output endpoint_pkg::bin_idx_t cut_bin_o,
  output spi_link_pkg::data_t    cut_mag_o,
  output logic                   ack_stb_o,
  output endpoint_pkg::ep_addr_e ack_addr_o,
  output spi_link_pkg::data_t    ack_data_o
);
  import spi_link_pkg::*;
  import endpoint_pkg::*;

  // ============================================================
  // cutoff registers
  // ============================================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cut_bin_o <= CUT_BIN_RESET;
      cut_mag_o <= CUT_MAG_RESET;
      ack_stb_o <= 1'b0;
    end else begin
      ack_stb_o <= cfg_stb_i;
      if (cfg_stb_i) begin
        if (cfg_sel_mag_i) begin
          cut_mag_o <= payload_i;
        end else begin
          // upper payload bits are dropped
          cut_bin_o <= payload_i[BIN_BITS-1:0];
        end
      end
    end
  end

  // ack echoes what was stored
  always_ff @(posedge clk_i) begin
    if (cfg_stb_i) begin
      if (cfg_sel_mag_i) begin
        ack_addr_o <= EP_CUT_MAG;
        ack_data_o <= payload_i;
      end else begin
        ack_addr_o <= EP_CUT_BIN;
        ack_data_o <= data_t'(payload_i[BIN_BITS-1:0]);
      end
    end
  end

endmodule

/* src/bin_classifier.sv */
`timescale 1ns/1ps

module bin_classifier (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   bin_stb_i,
  input  spi_link_pkg::data_t    payload_i,
  input  endpoint_pkg::bin_idx_t cut_bin_i,
  input  spi_link_pkg::data_t    cut_mag_i,
  output logic                   cls_stb_o,
  output logic                   cls_done_o,
  output logic                   cls_hit_o
);
  import endpoint_pkg::*;

  bin_idx_t bin_cnt_q;
  logic     hit_acc_q;
  logic     last_bin;
  logic     sample_hit;
  logic     block_hit;

  assign last_bin = (bin_cnt_q == bin_idx_t'(N_BINS - 1));

  // magnitudes are unsigned, strictly above the cutoff counts
  assign sample_hit = (bin_cnt_q >= cut_bin_i) && (payload_i > cut_mag_i);
  assign block_hit  = hit_acc_q | sample_hit;

  // ============================================================
  // bin counter and hit accumulator
  // ============================================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bin_cnt_q <= '0;
      hit_acc_q <= 1'b0;
    end else if (bin_stb_i) begin
      if (last_bin) begin
        bin_cnt_q <= '0;
        hit_acc_q <= 1'b0;
      end else begin
        bin_cnt_q <= bin_cnt_q + 1'b1;
        hit_acc_q <= block_hit;
      end
    end
  end

  // result of every sample, done only on the eighth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cls_stb_o  <= 1'b0;
      cls_done_o <= 1'b0;
      cls_hit_o  <= 1'b0;
    end else begin
      cls_stb_o <= bin_stb_i;
      if (bin_stb_i) begin
        cls_done_o <= last_bin;
        cls_hit_o  <= block_hit;
      end
    end
  end

endmodule

/* src/response_select.sv */
`timescale 1ns/1ps

module response_select (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  spi_link_pkg::data_t    payload_i,
  input  logic                   loop_stb_i,
  input  logic                   bad_stb_i,
  input  endpoint_pkg::ep_addr_e bad_addr_i,
  input  logic                   ack_stb_i,
  input  endpoint_pkg::ep_addr_e ack_addr_i,
  input  spi_link_pkg::data_t    ack_data_i,
  input  logic                   cls_stb_i,
  input  logic                   cls_done_i,
  input  logic                   cls_hit_i,
  output spi_link_pkg::frame_t   tx_frame_o
);
  import spi_link_pkg::*;
  import endpoint_pkg::*;

  data_t  cls_data;
  logic   resp_stb;
  frame_t resp_frame;

  // classifier reply, zero until the block completes
  always_comb begin
    cls_data                 = '0;
    cls_data[BLOCK_DONE_BIT] = cls_done_i;
    cls_data[0]              = cls_done_i & cls_hit_i;
  end

  // ============================================================
  // next response word
  // ============================================================
  always_comb begin
    resp_stb   = 1'b1;
    resp_frame = '0;
    if (loop_stb_i) begin
      resp_frame = {EP_LOOPBACK, payload_i};
    end else if (bad_stb_i) begin
      resp_frame = {BAD_ADDR_REPLY, BAD_DATA_REPLY};
    end else if (ack_stb_i) begin
      resp_frame = {ack_addr_i, ack_data_i};
    end else if (cls_stb_i) begin
      resp_frame = {EP_BIN, cls_data};
    end else begin
      resp_stb = 1'b0;
    end
  end

  // held until the next result replaces it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_frame_o <= '0;
    end else if (resp_stb) begin
      tx_frame_o <= resp_frame;
    end
  end

endmodule

/* src/spi_interconnect.sv */
`timescale 1ns/1ps

module spi_interconnect (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic cs_n_i,
  input  logic sclk_i,
  input  logic mosi_i,
  output logic miso_o
);
  import spi_link_pkg::*;
  import endpoint_pkg::*;

  logic     rx_stb;
  frame_t   rx_frame;
  frame_t   tx_frame;
  data_t    payload;
  logic     cfg_stb;
  logic     cfg_sel_mag;
  logic     bin_stb;
  logic     loop_stb;
  logic     bad_stb;
  ep_addr_e bad_addr;
  bin_idx_t cut_bin;
  data_t    cut_mag;
  logic     ack_stb;
  ep_addr_e ack_addr;
  data_t    ack_data;
  logic     cls_stb;
  logic     cls_done;
  logic     cls_hit;

  // ============================================================
  // SPI front end and address decode
  // ============================================================
  spi_minion spi_minion_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cs_n_i     (cs_n_i),
    .sclk_i     (sclk_i),
    .mosi_i     (mosi_i),
    .tx_frame_i (tx_frame),
    .miso_o     (miso_o),
    .rx_stb_o   (rx_stb),
    .rx_frame_o (rx_frame)
  );

  frame_router frame_router_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .rx_stb_i      (rx_stb),
    .rx_frame_i    (rx_frame),
    .payload_o     (payload),
    .cfg_stb_o     (cfg_stb),
    .cfg_sel_mag_o (cfg_sel_mag),
    .bin_stb_o     (bin_stb),
    .loop_stb_o    (loop_stb),
    .bad_stb_o     (bad_stb),
    .bad_addr_o    (bad_addr)
  );

  // ============================================================
  // endpoints
  // ============================================================
  config_bank config_bank_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cfg_stb_i     (cfg_stb),
    .cfg_sel_mag_i (cfg_sel_mag),
    .payload_i     (payload),
    .cut_bin_o     (cut_bin),
    .cut_mag_o     (cut_mag),
    .ack_stb_o     (ack_stb),
    .ack_addr_o    (ack_addr),
    .ack_data_o    (ack_data)
  );

  bin_classifier bin_classifier_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bin_stb_i  (bin_stb),
    .payload_i  (payload),
    .cut_bin_i  (cut_bin),
    .cut_mag_i  (cut_mag),
    .cls_stb_o  (cls_stb),
    .cls_done_o (cls_done),
    .cls_hit_o  (cls_hit)
  );

  // response goes back out in the next frame
  response_select response_select_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .payload_i  (payload),
    .loop_stb_i (loop_stb),
    .bad_stb_i  (bad_stb),
    .bad_addr_i (bad_addr),
    .ack_stb_i  (ack_stb),
    .ack_addr_i (ack_addr),
    .ack_data_i (ack_data),
    .cls_stb_i  (cls_stb),
    .cls_done_i (cls_done),
    .cls_hit_i  (cls_hit),
    .tx_frame_o (tx_frame)
  );

endmodule

/* tb/tb_spi_interconnect.sv */
`timescale 1ns/1ps

module tb_spi_interconnect;
  import spi_link_pkg::*;
  import endpoint_pkg::*;

  localparam int HALF_PHASE = 4;
  localparam int FRAME_GAP = 20;
  localparam int DRAIN_CYCLES = 16;
  localparam int WATCHDOG_CYCLES = 100000;

  logic clk_i;
  logic rst_n_i;
  logic cs_n_i;
  logic sclk_i;
  logic mosi_i;
  logic miso_o;

  // reference model state
  bin_idx_t    m_cut_bin = CUT_BIN_RESET;
  data_t       m_cut_mag = CUT_MAG_RESET;
  int          m_bin_cnt = 0;
  logic        m_acc = 1'b0;
  frame_t      ref_pending = '0;
  logic [31:0] lfsr_q = 32'h10eb_3a80;

  // returned frames waiting for the compare process
  frame_t got_q[$];
  frame_t exp_q[$];
  event   frame_done;

  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int err_mark = 0;
  int check_mark = 0;

  spi_interconnect spi_interconnect_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cs_n_i  (cs_n_i),
    .sclk_i  (sclk_i),
    .mosi_i  (mosi_i),
    .miso_o  (miso_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ============================================================
  // stimulus helpers
  // ============================================================
  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
    end
  endtask

  // mode 0 host, miso sampled mid-cycle while sclk is high
  task automatic spi_xfer(input frame_t tx, input int nbits, output frame_t rx);
    rx = '0;
    @(posedge clk_i);
    cs_n_i <= 1'b0;
    mosi_i <= tx[FRAME_BITS-1];
    idle_cycles(HALF_PHASE);
    for (int i = 0; i < nbits; i++) begin
      @(posedge clk_i);
      sclk_i <= 1'b1;
      @(negedge clk_i);
      rx = {rx[FRAME_BITS-2:0], miso_o};
      idle_cycles(HALF_PHASE - 1);
      @(posedge clk_i);
      sclk_i <= 1'b0;
      mosi_i <= (i < FRAME_BITS - 1) ? tx[FRAME_BITS-2-i] : 1'b0;
      idle_cycles(HALF_PHASE - 1);
    end
    @(posedge clk_i);
    cs_n_i <= 1'b1;
    mosi_i <= 1'b0;
    idle_cycles(FRAME_GAP);
  endtask

  // ============================================================
  // reference model
  // ============================================================
  function automatic frame_t ref_step(input frame_t tx);
    logic [ADDR_BITS-1:0] addr;
    data_t                d;
    frame_t               resp;
    addr = tx[FRAME_BITS-1 -: ADDR_BITS];
    d = tx[DATA_BITS-1:0];
    case (addr)
      EP_LOOPBACK: resp = {EP_LOOPBACK, d};
      EP_CUT_BIN: begin
        m_cut_bin = d[2:0];
        resp = {EP_CUT_BIN, 13'd0, d[2:0]};
      end
      EP_CUT_MAG: begin
        m_cut_mag = d;
        resp = {EP_CUT_MAG, d};
      end
      EP_BIN: begin
        m_acc = m_acc | ((m_bin_cnt >= int'(m_cut_bin)) && (d > m_cut_mag));
        resp = {EP_BIN, 16'h0000};
        if (m_bin_cnt == N_BINS - 1) begin
          resp[BLOCK_DONE_BIT] = 1'b1;
          resp[0] = m_acc;
          m_acc = 1'b0;
          m_bin_cnt = 0;
        end else begin
          m_bin_cnt = m_bin_cnt + 1;
        end
      end
      default: resp = {BAD_ADDR_REPLY, BAD_DATA_REPLY};
    endcase
    return resp;
  endfunction

  // full frame, its reply is predicted from the frame before
  task automatic transfer(input frame_t tx, output frame_t rx);
    frame_t exp;
    exp = ref_pending;
    spi_xfer(tx, FRAME_BITS, rx);
    got_q.push_back(rx);
    exp_q.push_back(exp);
    ref_pending = ref_step(tx);
    -> frame_done;
  endtask

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic check_frame(input frame_t got, input frame_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got 0x%05h expected 0x%05h", what, got, exp);
    end
  endtask

  task automatic check_addr(input ep_addr_e got, input ep_addr_e exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got 0x%01h expected 0x%01h", what, got, exp);
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got 0x%04h expected 0x%04h", what, got, exp);
    end
  endtask

  initial begin : compare_proc
    frame_t got;
    frame_t exp;
    forever begin
      @(frame_done);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        exp = exp_q.pop_front();
        check_addr(ep_addr_e'(got[FRAME_BITS-1 -: ADDR_BITS]),
                   ep_addr_e'(exp[FRAME_BITS-1 -: ADDR_BITS]), "miso_o address field");
        check_data(got[DATA_BITS-1:0], exp[DATA_BITS-1:0], "miso_o data field");
      end
    end
  end

  // all returned frames are compared before the test is closed
  task automatic end_test(input string name);
    int waited;
    waited = 0;
    while ((got_q.size() > 0) && (waited < DRAIN_CYCLES)) begin
      @(posedge clk_i);
      waited++;
    end
    if (got_q.size() > 0) begin
      err_cnt++;
      $display("%0d returned frames were still not compared after %0d clock cycles",
               got_q.size(), DRAIN_CYCLES);
    end
    test_cnt++;
    $display("test %0d %s: %0d checks, %0d errors", test_cnt, name,
             check_cnt - check_mark, err_cnt - err_mark);
    check_mark = check_cnt;
    err_mark = err_cnt;
  endtask

  initial begin : watchdog
    for (int i = 0; i < WATCHDOG_CYCLES; i++) begin
      @(posedge clk_i);
    end
    $display("timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // ============================================================
  // tests
  // ============================================================
  initial begin : main_proc
    frame_t      got;
    frame_t      last_valid;
    data_t       d;
    bin_idx_t    cut_bins[4];
    data_t       cut_mags[4];
    logic [3:0]  bad_addrs[3];
    rst_n_i = 1'b0;
    cs_n_i = 1'b1;
    sclk_i = 1'b0;
    mosi_i = 1'b0;
    cut_bins = '{3'd0, 3'd5, 3'd3, 3'd7};
    cut_mags = '{16'hC000, 16'h8000, 16'h2000, 16'hFFFF};
    bad_addrs = '{4'h0, 4'h5, 4'hF};
    idle_cycles(16);
    rst_n_i <= 1'b1;
    idle_cycles(4);

    transfer({EP_LOOPBACK, 16'h1234}, got);
    check_frame(got, '0, "miso_o first frame after reset");
    end_test("reset");

    for (int i = 0; i < 20; i++) begin
      transfer({EP_LOOPBACK, data_t'(rand_bits(DATA_BITS))}, got);
    end
    end_test("loopback");

    // bin writes keep only the low 3 bits
    transfer({EP_CUT_BIN, 16'hFFFB}, got);
    transfer({EP_CUT_BIN, 16'h0012}, got);
    transfer({EP_CUT_MAG, data_t'(rand_bits(DATA_BITS))}, got);
    transfer({EP_CUT_BIN, data_t'(rand_bits(DATA_BITS))}, got);
    transfer({EP_CUT_MAG, 16'h7FFF}, got);
    transfer({EP_LOOPBACK, 16'h0000}, got);
    end_test("config");

    for (int c = 0; c < 4; c++) begin
      transfer({EP_CUT_BIN, 13'd0, cut_bins[c]}, got);
      transfer({EP_CUT_MAG, cut_mags[c]}, got);
      for (int s = 0; s < 2 * N_BINS; s++) begin
        transfer({EP_BIN, data_t'(rand_bits(DATA_BITS))}, got);
      end
    end
    transfer({EP_LOOPBACK, 16'h0000}, got);
    end_test("classifier");

    for (int i = 0; i < 3; i++) begin
      transfer({bad_addrs[i], data_t'(rand_bits(DATA_BITS))}, got);
      if (i > 0) begin
        check_frame(got, {BAD_ADDR_REPLY, BAD_DATA_REPLY}, "miso_o unmapped reply");
      end
    end
    transfer({EP_LOOPBACK, 16'h0000}, got);
    check_frame(got, {BAD_ADDR_REPLY, BAD_DATA_REPLY}, "miso_o unmapped reply");
    end_test("bad_addr");

    d = data_t'(rand_bits(DATA_BITS));
    transfer({EP_LOOPBACK, d}, got);
    last_valid = {EP_LOOPBACK, d};
    // cut short, the model is not stepped
    spi_xfer({EP_LOOPBACK, data_t'(rand_bits(DATA_BITS))}, 12, got);
    transfer({EP_LOOPBACK, 16'h5A5A}, got);
    check_frame(got, last_valid, "miso_o frame after abort");
    end_test("abort");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* sim.f */
src/spi_link_pkg.sv
src/endpoint_pkg.sv
src/spi_minion.sv
src/frame_router.sv
src/config_bank.sv
src/bin_classifier.sv
src/response_select.sv
src/spi_interconnect.sv
tb/tb_spi_interconnect.sv
